// ==== logic/oflow_pkg.sv ====
package oflow_pkg;

	localparam int key_width = 4; // task id and physical core id
	localparam int key_size = 16; // number of task ids
	localparam int count_width = 8; // fingerprint count and max count
	localparam int data_width = 32; // bus write data
	localparam int address_width = 32; // bus address
	localparam int fifo_depth = 8; // entries per event queue
	localparam int fifo_ptr_width = $clog2(fifo_depth);

	localparam logic [address_width-1:0] oflow_offset = 32'h0800_0000; // notice region base
	localparam int core_shift = 20; // physical core id lands at address bit 20
	localparam int kind_pos = 8; // kind flag sits above core id and task id
	localparam int notice_base = 512; // added to every notice word

	// csr max count word layout, task id above the value
	localparam int csr_value_pos = 0;
	localparam int csr_task_pos = count_width;

	typedef logic [key_width-1:0] key_t;
	typedef logic [count_width-1:0] count_t;

	// one queued notice, core id in the upper nibble
	typedef struct packed {
		key_t core_id;
		key_t task_id;
	} oflow_event_t;

	typedef enum logic [2:0] {
		idle,
		overflow_read, // pop the overflow queue
		underflow_read, // pop the underflow queue
		overflow_load, // rd_data valid, latch with kind 1
		underflow_load, // rd_data valid, latch with kind 0
		bus_write // hold write until waitrequest drops
	} notifier_state_t;

endpackage

// ==== logic/count_if.sv ====
`timescale 1ns/10ps

interface count_if;
	import oflow_pkg::*;

	logic inc; // single cycle increment strobe
	logic dec; // single cycle decrement strobe
	key_t inc_task;
	key_t dec_task;
	key_t inc_core; // physical core behind the increment
	logic inc_lc; // logical core of the increment
	logic dec_lc; // logical core of the decrement

	modport tracker (
		input inc, dec, inc_task, dec_task, inc_core, inc_lc, dec_lc
	);

	modport source (
		output inc, dec, inc_task, dec_task, inc_core, inc_lc, dec_lc
	);

endinterface

// ==== logic/event_fifo.sv ====
`timescale 1ns/10ps

module event_fifo (
	input logic clk,
	input logic reset,
	input logic push,
	input oflow_pkg::oflow_event_t wr_data,
	input logic pop,
	output oflow_pkg::oflow_event_t rd_data,
	output logic empty,
	output logic full
);
	import oflow_pkg::*;

	oflow_event_t mem [fifo_depth]; // event storage
	logic [fifo_ptr_width-1:0] wr_ptr;
	logic [fifo_ptr_width-1:0] rd_ptr;
	logic [fifo_ptr_width:0] count; // entries held
	logic do_push;
	logic do_pop;

	assign full = (count == (fifo_ptr_width+1)'(fifo_depth));
	assign do_push = push & ~full; // new event dropped when full
	assign do_pop = pop & (count != '0);

	// pointers and occupancy
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			empty <= 1'b1;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			empty <= (count == '0); // flag trails the count by a cycle
		end
	end

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
		if (do_pop)
			rd_data <= mem[rd_ptr]; // valid the cycle after pop
	end

endmodule

// ==== logic/count_tracker.sv ====
`timescale 1ns/10ps

module count_tracker (
	input logic clk,
	input logic reset,
	count_if.tracker cnt,
	input logic csr_maxcount_write,
	input logic [oflow_pkg::data_width-1:0] csr_maxcount_writedata,
	output logic ovf_push,
	output oflow_pkg::oflow_event_t ovf_event,
	output logic unf_push,
	output oflow_pkg::oflow_event_t unf_event
);
	import oflow_pkg::*;

	count_t max_count [key_size]; // per task limit
	count_t lc_count [2][key_size]; // one count array per logical core
	logic rec_valid [key_size]; // overflow on record
	key_t rec_core [key_size]; // physical core that overflowed

	key_t csr_task;
	count_t csr_value;
	logic cancel;
	logic inc_eff;
	logic dec_eff;
	count_t inc_next; // incremented count on inc_lc
	count_t dec_after [2]; // both cores of dec_task after this cycle
	logic ovf_hit;
	logic unf_hit;

	assign csr_task = csr_maxcount_writedata[csr_task_pos +: key_width];
	assign csr_value = csr_maxcount_writedata[csr_value_pos +: count_width];

	// inc and dec on the same task and logical core cancel out
	assign cancel = cnt.inc & cnt.dec & (cnt.inc_task == cnt.dec_task) &
		(cnt.inc_lc == cnt.dec_lc);
	assign inc_eff = cnt.inc & ~cancel;
	assign dec_eff = cnt.dec & ~cancel;

	assign inc_next = lc_count[cnt.inc_lc][cnt.inc_task] + 1'b1;

	// post-update counts of the decremented task, including any inc on it
	always_comb begin
		for (int c = 0; c < 2; c++) begin
			dec_after[c] = lc_count[c][cnt.dec_task];
			if (inc_eff && (cnt.inc_lc == c[0]) && (cnt.inc_task == cnt.dec_task))
				dec_after[c] = dec_after[c] + 1'b1;
			if (dec_eff && (cnt.dec_lc == c[0]))
				dec_after[c] = dec_after[c] - 1'b1;
		end
	end

	// first time a core reaches max count
	assign ovf_hit = inc_eff & (inc_next >= max_count[cnt.inc_task]) &
		~rec_valid[cnt.inc_task];

	// both cores drained on a task with a record
	assign unf_hit = dec_eff & (dec_after[0] == '0) & (dec_after[1] == '0) &
		rec_valid[cnt.dec_task];

	assign ovf_push = ovf_hit;
	assign ovf_event.core_id = cnt.inc_core; // incoming physical core
	assign ovf_event.task_id = cnt.inc_task;
	assign unf_push = unf_hit;
	assign unf_event.core_id = rec_core[cnt.dec_task]; // recorded physical core
	assign unf_event.task_id = cnt.dec_task;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int t = 0; t < key_size; t++) begin
				max_count[t] <= '0;
				lc_count[0][t] <= '0;
				lc_count[1][t] <= '0;
				rec_valid[t] <= 1'b0;
				rec_core[t] <= '0;
			end
		end else begin
			if (csr_maxcount_write)
				max_count[csr_task] <= csr_value;
			// inc and dec never hit the same entry once cancel is applied
			if (inc_eff)
				lc_count[cnt.inc_lc][cnt.inc_task] <= inc_next;
			if (dec_eff)
				lc_count[cnt.dec_lc][cnt.dec_task] <= lc_count[cnt.dec_lc][cnt.dec_task] - 1'b1;
			if (ovf_hit) begin
				rec_valid[cnt.inc_task] <= 1'b1;
				rec_core[cnt.inc_task] <= cnt.inc_core;
			end
			if (unf_hit)
				rec_valid[cnt.dec_task] <= 1'b0; // never same task as ovf_hit
		end
	end

endmodule

// ==== logic/oflow_notifier.sv ====
`timescale 1ns/10ps

module oflow_notifier (
	input logic clk,
	input logic reset,
	input logic ovf_empty,
	input oflow_pkg::oflow_event_t ovf_data,
	input logic unf_empty,
	input oflow_pkg::oflow_event_t unf_data,
	input logic oflow_waitrequest,
	output logic ovf_pop,
	output logic unf_pop,
	output logic oflow_write,
	output logic [oflow_pkg::address_width-1:0] oflow_address,
	output logic [oflow_pkg::data_width-1:0] oflow_writedata
);
	import oflow_pkg::*;

	notifier_state_t state;
	logic [kind_pos:0] notice; // kind flag over core id and task id
	oflow_event_t notice_event;

	// bus arbiter, overflow queue wins
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (!ovf_empty)
						state <= overflow_read;
					else if (!unf_empty)
						state <= underflow_read;
				end
				overflow_read: state <= overflow_load;
				underflow_read: state <= underflow_load;
				overflow_load: state <= bus_write;
				underflow_load: state <= bus_write;
				bus_write: begin
					if (!oflow_waitrequest)
						state <= idle; // transfer accepted
				end
				default: state <= idle;
			endcase
		end
	end

	// latch popped record, rd_data is valid in the load states
	always_ff @(posedge clk) begin
		if (state == overflow_load)
			notice <= {1'b1, ovf_data};
		else if (state == underflow_load)
			notice <= {1'b0, unf_data};
	end

	assign ovf_pop = (state == overflow_read);
	assign unf_pop = (state == underflow_read);

	assign notice_event = oflow_event_t'(notice[kind_pos-1:0]);

	// held stable for the whole bus_write state
	assign oflow_write = (state == bus_write);
	assign oflow_address = oflow_offset +
		(address_width'(notice_event.core_id) << core_shift);
	assign oflow_writedata = data_width'(notice_base) + data_width'(notice);

endmodule

// ==== logic/oflow_registers.sv ====
`timescale 1ns/10ps

module oflow_registers (
	input logic clk,
	input logic reset,
	output logic oflow_write,
	output logic [oflow_pkg::data_width-1:0] oflow_writedata,
	output logic [oflow_pkg::address_width-1:0] oflow_address,
	input logic oflow_waitrequest,
	input logic csr_maxcount_write,
	input logic [oflow_pkg::data_width-1:0] csr_maxcount_writedata,
	input logic count_inc,
	input logic count_dec,
	input logic [oflow_pkg::key_width-1:0] count_inc_physical_core_id,
	input logic [oflow_pkg::key_width-1:0] count_inc_task_id,
	input logic [oflow_pkg::key_width-1:0] count_dec_task_id,
	input logic count_inc_logical_core_id,
	input logic count_dec_logical_core_id
);
	import oflow_pkg::*;

	logic ovf_push;
	logic unf_push;
	oflow_event_t ovf_event;
	oflow_event_t unf_event;
	logic ovf_empty;
	logic unf_empty;
	oflow_event_t ovf_data;
	oflow_event_t unf_data;
	logic ovf_pop;
	logic unf_pop;

	count_if cnt (); // strobe bundle, source side driven here

	assign cnt.inc = count_inc;
	assign cnt.dec = count_dec;
	assign cnt.inc_task = count_inc_task_id;
	assign cnt.dec_task = count_dec_task_id;
	assign cnt.inc_core = count_inc_physical_core_id;
	assign cnt.inc_lc = count_inc_logical_core_id;
	assign cnt.dec_lc = count_dec_logical_core_id;

	count_tracker u_count_tracker (
		.clk(clk),
		.reset(reset),
		.cnt(cnt.tracker),
		.csr_maxcount_write(csr_maxcount_write),
		.csr_maxcount_writedata(csr_maxcount_writedata),
		.ovf_push(ovf_push),
		.ovf_event(ovf_event),
		.unf_push(unf_push),
		.unf_event(unf_event)
	);

	// full only gates pushes inside the queue
	event_fifo u_ovf_fifo (
		.clk(clk),
		.reset(reset),
		.push(ovf_push),
		.wr_data(ovf_event),
		.pop(ovf_pop),
		.rd_data(ovf_data),
		.empty(ovf_empty),
		.full()
	);

	event_fifo u_unf_fifo (
		.clk(clk),
		.reset(reset),
		.push(unf_push),
		.wr_data(unf_event),
		.pop(unf_pop),
		.rd_data(unf_data),
		.empty(unf_empty),
		.full()
	);

	oflow_notifier u_oflow_notifier (
		.clk(clk),
		.reset(reset),
		.ovf_empty(ovf_empty),
		.ovf_data(ovf_data),
		.unf_empty(unf_empty),
		.unf_data(unf_data),
		.oflow_waitrequest(oflow_waitrequest),
		.ovf_pop(ovf_pop),
		.unf_pop(unf_pop),
		.oflow_write(oflow_write),
		.oflow_address(oflow_address),
		.oflow_writedata(oflow_writedata)
	);

endmodule

// ==== bench/oflow_model.svh ====
`ifndef OFLOW_MODEL_SVH
`define OFLOW_MODEL_SVH

int model_count [2][key_size]; // per logical core, per task
int model_max [key_size];
bit model_rec [key_size]; // overflow on record
key_t model_core [key_size]; // recorded physical core
oflow_event_t exp_ovf [$]; // overflow notices still to be written
oflow_event_t exp_unf [$];
int exp_ovf_cycle [$]; // push edge of each pending overflow notice

// predicts the edge that samples these inputs
task automatic model_step(input logic inc, input logic dec, input key_t itask,
	input key_t dtask, input key_t icore, input logic ilc, input logic dlc,
	input logic csr_we, input logic [data_width-1:0] csr_data, input int push_cycle);
	oflow_event_t ev;
	bit cancel;
	bit ovf;
	bit unf;
	cancel = inc && dec && (itask == dtask) && (ilc == dlc); // same counter, no net change
	ovf = 0;
	unf = 0;
	if (inc && !cancel) begin
		model_count[ilc][itask]++;
		ovf = (model_count[ilc][itask] >= model_max[itask]) && !model_rec[itask];
	end
	if (dec && !cancel) begin
		model_count[dlc][dtask]--;
		unf = (model_count[0][dtask] == 0) && (model_count[1][dtask] == 0) && model_rec[dtask];
	end
	if (ovf) begin
		model_rec[itask] = 1; // first overflow only
		model_core[itask] = icore;
		ev.core_id = icore;
		ev.task_id = itask;
		exp_ovf.push_back(ev);
		exp_ovf_cycle.push_back(push_cycle);
	end
	if (unf) begin
		ev.core_id = model_core[dtask]; // core from the record
		ev.task_id = dtask;
		model_rec[dtask] = 0;
		exp_unf.push_back(ev);
	end
	if (csr_we)
		model_max[csr_data[11:8]] = int'(csr_data[7:0]); // old max used above
endtask

`endif

// ==== bench/tb_oflow_registers.sv ====
`timescale 1ns/10ps

module tb_oflow_registers;
	import oflow_pkg::*;

	localparam int n_random = 300; // random stimulus cycles
	localparam int drain_limit = 120; // cycles allowed to deliver pending notices
	localparam int stim_cycles = 3 + 20 + n_random + 6 * (drain_limit + 30);

	logic clk = 1'b0;
	logic reset;
	logic oflow_write;
	logic [data_width-1:0] oflow_writedata;
	logic [address_width-1:0] oflow_address;
	logic oflow_waitrequest;
	logic csr_maxcount_write;
	logic [data_width-1:0] csr_maxcount_writedata;
	logic count_inc;
	logic count_dec;
	key_t count_inc_physical_core_id;
	key_t count_inc_task_id;
	key_t count_dec_task_id;
	logic count_inc_logical_core_id;
	logic count_dec_logical_core_id;

	int cycle = 0; // index of the last rising edge
	int rise_cycle = -1; // edge after which oflow_write last rose
	bit write_seen = 0;
	bit random_wait = 0; // bus responder mode
	int errors = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int n_ovf_wr = 0; // accepted overflow writes
	int n_unf_wr = 0;

	`include "oflow_model.svh"

	oflow_registers u_oflow_registers (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic check_address(input logic [address_width-1:0] exp,
		input logic [address_width-1:0] got);
		if (got !== exp) begin
			$display("error oflow_address expected %h got %h", exp, got);
			errors++;
		end
	endtask

	task automatic check_writedata(input logic [data_width-1:0] exp,
		input logic [data_width-1:0] got);
		if (got !== exp) begin
			$display("error oflow_writedata expected %h got %h", exp, got);
			errors++;
		end
	endtask

	task automatic check_event(input oflow_event_t exp, input oflow_event_t got);
		if (got !== exp) begin
			$display("error oflow_event expected %h got %h", exp, got);
			errors++;
		end
	endtask

	task automatic check_total(input string what, input int exp, input int got);
		if (got != exp) begin
			$display("error %s expected %h got %h", what, exp, got);
			errors++;
		end
	endtask

	// underflow granted while an overflow was visible to the arbiter
	task automatic check_priority();
		logic [data_width-1:0] raw;
		bit waiting;
		raw = oflow_writedata - data_width'(notice_base);
		waiting = 0;
		foreach (exp_ovf_cycle[i])
			if (exp_ovf_cycle[i] <= rise_cycle - 4) // non-empty at the idle decision edge
				waiting = 1;
		if (!raw[kind_pos] && waiting) begin
			$display("underflow write granted while an overflow notice was waiting");
			errors++;
		end
	endtask

	task automatic accept_write();
		logic [data_width-1:0] raw;
		oflow_event_t got;
		oflow_event_t exp;
		logic exp_kind;
		raw = oflow_writedata - data_width'(notice_base);
		got = oflow_event_t'(raw[kind_pos-1:0]);
		if (raw[kind_pos] ? (exp_ovf.size() == 0) : (exp_unf.size() == 0)) begin
			$display("unexpected notice write with kind %0d", raw[kind_pos]);
			errors++;
		end else begin
			if (raw[kind_pos]) begin
				exp = exp_ovf.pop_front();
				void'(exp_ovf_cycle.pop_front());
				exp_kind = 1'b1; // overflow notice
				n_ovf_wr++;
			end else begin
				exp = exp_unf.pop_front();
				exp_kind = 1'b0;
				n_unf_wr++;
			end
			check_event(exp, got);
			check_address(oflow_offset + (address_width'(exp.core_id) << core_shift), oflow_address);
			check_writedata(data_width'(notice_base) + data_width'({exp_kind, exp}),
				oflow_writedata);
		end
	endtask

	// bus side, sampled mid cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (oflow_write && !write_seen) begin
				rise_cycle = cycle;
				check_priority();
			end
			write_seen = oflow_write;
			if (oflow_write && !oflow_waitrequest)
				accept_write(); // completes on the next edge
		end
	end

	// inputs set now are sampled by the next edge
	task automatic step();
		model_step(count_inc, count_dec, count_inc_task_id, count_dec_task_id,
			count_inc_physical_core_id, count_inc_logical_core_id, count_dec_logical_core_id,
			csr_maxcount_write, csr_maxcount_writedata, cycle + 1);
		@(posedge clk);
		#1;
		count_inc = 1'b0;
		count_dec = 1'b0;
		csr_maxcount_write = 1'b0;
		oflow_waitrequest = random_wait ? 1'($urandom_range(0, 1)) : 1'b0;
	endtask

	task automatic pulse_inc(input key_t t, input key_t core, input logic lc);
		count_inc = 1'b1;
		count_inc_task_id = t;
		count_inc_physical_core_id = core;
		count_inc_logical_core_id = lc;
		step();
	endtask

	task automatic pulse_dec(input key_t t, input logic lc);
		count_dec = 1'b1;
		count_dec_task_id = t;
		count_dec_logical_core_id = lc;
		step();
	endtask

	task automatic write_max(input key_t t, input count_t value);
		csr_maxcount_write = 1'b1;
		csr_maxcount_writedata = data_width'({t, value}); // task id in bits 11:8
		step();
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((exp_ovf.size() != 0 || exp_unf.size() != 0) && n < drain_limit) begin
			step();
			n++;
		end
		if (exp_ovf.size() != 0 || exp_unf.size() != 0) begin
			$display("%0d overflow and %0d underflow notices never written",
				exp_ovf.size(), exp_unf.size());
			errors++;
		end
		repeat (8) step(); // room for stray writes
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, errors - test_errors);
			tests_failed++;
		end
		test_errors = errors;
	endtask

	initial begin
		#(20 * stim_cycles * 10);
		$display("timeout after %0d ns, run stopped", 20 * stim_cycles * 10);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int base_ovf;
		int base_unf;
		int lat_push;
		void'($urandom(52));
		reset = 1'b1;
		oflow_waitrequest = 1'b0;
		csr_maxcount_write = 1'b0;
		csr_maxcount_writedata = '0;
		count_inc = 1'b0;
		count_dec = 1'b0;
		count_inc_physical_core_id = '0;
		count_inc_task_id = '0;
		count_dec_task_id = '0;
		count_inc_logical_core_id = 1'b0;
		count_dec_logical_core_id = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (20) begin
			step();
			if (oflow_write) begin
				$display("oflow_write went high with no strobes");
				errors++;
			end
		end
		end_test("idle after reset");

		random_wait = 1;
		base_ovf = n_ovf_wr;
		write_max(4'd3, 8'd5);
		repeat (7) pulse_inc(4'd3, 4'd7, 1'b0); // overflow at five, then nothing
		drain();
		check_total("overflow writes", 1, n_ovf_wr - base_ovf);
		end_test("max count and overflow");

		base_ovf = n_ovf_wr;
		base_unf = n_unf_wr;
		repeat (2) pulse_inc(4'd3, 4'd9, 1'b1); // record already held
		repeat (7) pulse_dec(4'd3, 1'b0);
		repeat (2) pulse_dec(4'd3, 1'b1); // both cores now at zero
		write_max(4'd5, 8'd10);
		repeat (2) pulse_inc(4'd5, 4'd2, 1'b0);
		repeat (2) pulse_dec(4'd5, 1'b0); // no record, no notice
		drain();
		check_total("underflow writes", 1, n_unf_wr - base_unf);
		check_total("overflow writes", 0, n_ovf_wr - base_ovf);
		end_test("underflow");

		base_ovf = n_ovf_wr;
		write_max(4'd6, 8'd4);
		repeat (2) pulse_inc(4'd6, 4'd4, 1'b0);
		count_dec = 1'b1; // cancels with the inc below
		count_dec_task_id = 4'd6;
		count_dec_logical_core_id = 1'b0;
		pulse_inc(4'd6, 4'd4, 1'b0);
		pulse_inc(4'd6, 4'd4, 1'b0);
		drain();
		check_total("overflow writes", 0, n_ovf_wr - base_ovf); // count only at three
		pulse_inc(4'd6, 4'd4, 1'b0);
		drain();
		check_total("overflow writes", 1, n_ovf_wr - base_ovf);
		end_test("inc and dec cancel");

		for (int i = 0; i < n_random; i++) begin
			if (exp_ovf.size() < fifo_depth - 2 && exp_unf.size() < fifo_depth - 2) begin
				if ($urandom_range(0, 9) == 0) begin
					csr_maxcount_write = 1'b1;
					csr_maxcount_writedata = data_width'({key_t'($urandom_range(0, 3)),
						count_t'($urandom_range(1, 6))});
				end else begin
					count_inc_task_id = key_t'($urandom_range(0, 3)); // few tasks, many events
					count_inc_physical_core_id = key_t'($urandom);
					count_inc_logical_core_id = 1'($urandom_range(0, 1));
					count_dec_task_id = key_t'($urandom_range(0, 3));
					count_dec_logical_core_id = 1'($urandom_range(0, 1));
					count_inc = 1'($urandom_range(0, 1)) &&
						(model_count[count_inc_logical_core_id][count_inc_task_id] < 255);
					count_dec = 1'($urandom_range(0, 1)) &&
						(model_count[count_dec_logical_core_id][count_dec_task_id] > 0);
				end
			end
			step();
		end
		drain();
		end_test("random back-pressure and priority");

		random_wait = 0; // bus always ready
		write_max(4'd10, 8'd1);
		repeat (4) step();
		lat_push = cycle + 1; // edge that samples the strobe
		pulse_inc(4'd10, 4'd11, 1'b0);
		drain();
		if (rise_cycle - lat_push != 4) begin
			$display("oflow_write rose %0d cycles after the strobe, not 4", rise_cycle - lat_push);
			errors++;
		end
		end_test("fixed latency");

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+bench
logic/oflow_pkg.sv
logic/count_if.sv
logic/event_fifo.sv
logic/count_tracker.sv
logic/oflow_notifier.sv
logic/oflow_registers.sv
bench/tb_oflow_registers.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = tb_oflow_registers
FILELIST = verilog.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the run reports success"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
